// ==== list.f ====
rtl/rdbank_pkg.sv
rtl/rdbank_beat_store.sv
rtl/rdbank_slot_table.sv
rtl/rdbank_id_lists.sv
rtl/rdbank_release_arbiter.sv
rtl/read_data_bank.sv
testbench/tb_read_data_bank.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the read data bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_read_data_bank \
  -Mdir obj_dir -o tb_read_data_bank
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_read_data_bank > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== testbench/tb_read_data_bank.sv ====
// Read data bank testbench: stimulus table, reference model, per-cycle checks and timeouts

`timescale 1ns/1ps

module tb_read_data_bank;

  localparam int NumIds = rdbank_pkg::NumIds;
  localparam int TotalCapacity = rdbank_pkg::TotalCapacity;
  localparam int MaxBurstLen = rdbank_pkg::MaxBurstLen;
  localparam int DataWidth = rdbank_pkg::DataWidth;
  localparam int IdWidth = rdbank_pkg::IdWidth;
  localparam int BankAddrWidth = rdbank_pkg::BankAddrWidth;
  localparam int BurstLenWidth = rdbank_pkg::BurstLenWidth;
  // Cycles any single wait may take
  localparam int WaitLimit = 60;

  typedef enum {ROW_RESERVE, ROW_WRITE, ROW_MASK, ROW_DRAIN} row_kind_e;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     i_res_valid;
  logic [IdWidth-1:0]       i_res_id;
  logic [BurstLenWidth-1:0] i_res_burst_len;
  logic                     o_res_ready;
  logic [BankAddrWidth-1:0] o_res_addr;
  logic                     i_in_valid;
  logic [IdWidth-1:0]       i_in_id;
  logic [DataWidth-1:0]     i_in_content;
  logic                     o_in_ready;
  logic [TotalCapacity-1:0] i_release_en;
  logic                     o_out_valid;
  logic [IdWidth-1:0]       o_out_id;
  logic [DataWidth-1:0]     o_out_content;
  logic                     i_out_ready;
  logic [TotalCapacity-1:0] o_released_onehot;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////////////////////////////////

  // State, owner, reservation order, length and beat counts of each slot
  rdbank_pkg::slot_state_e slot_state [TotalCapacity];
  int                   slot_id   [TotalCapacity];
  int                   slot_seq  [TotalCapacity];
  int                   slot_len  [TotalCapacity];
  int                   slot_rcvd [TotalCapacity];
  int                   slot_sent [TotalCapacity];
  logic [DataWidth-1:0] slot_data [TotalCapacity][MaxBurstLen];
  int                   next_seq;

  // Choice held while the requester stalls
  bit locked;
  int lock_id;
  int lock_slot;

  // Expectations of the current cycle
  bit exp_valid;
  bit res_hs;
  bit in_hs;
  bit out_hs;
  int exp_res_addr;
  int exp_fill;
  int exp_out_id;
  int exp_out_slot;

  // Stimulus table
  row_kind_e                row_kind [$];
  int                       row_a [$];
  int                       row_b [$];
  logic [TotalCapacity-1:0] release_mask;
  int                       seed = 11857;

  read_data_bank #(
    .NumIds        (NumIds),
    .TotalCapacity (TotalCapacity),
    .MaxBurstLen   (MaxBurstLen),
    .DataWidth     (DataWidth)
  ) dut_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_res_valid       (i_res_valid),
    .i_res_id          (i_res_id),
    .i_res_burst_len   (i_res_burst_len),
    .o_res_ready       (o_res_ready),
    .o_res_addr        (o_res_addr),
    .i_in_valid        (i_in_valid),
    .i_in_id           (i_in_id),
    .i_in_content      (i_in_content),
    .o_in_ready        (o_in_ready),
    .i_release_en      (i_release_en),
    .o_out_valid       (o_out_valid),
    .o_out_id          (o_out_id),
    .o_out_content     (o_out_content),
    .i_out_ready       (i_out_ready),
    .o_released_onehot (o_released_onehot)
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Checks and model lookups
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_equal(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timed out after %0d cycles waiting for %s", WaitLimit, what);
    $display("CHECKS FAILED");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  // Oldest slot of an identifier or only its oldest unfilled slot
  function automatic int oldest_slot(int id, bit unfilled_only);
    int best;
    best = -1;
    for (int s = 0; s < TotalCapacity; s++) begin
      if ((slot_state[s] != rdbank_pkg::SLOT_FREE) && (slot_id[s] == id) &&
          (!unfilled_only || (slot_state[s] == rdbank_pkg::SLOT_FILLING))) begin
        if ((best < 0) || (slot_seq[s] < slot_seq[best])) begin
          best = s;
        end
      end
    end
    return best;
  endfunction

  function automatic int lowest_free();
    for (int s = 0; s < TotalCapacity; s++) begin
      if (slot_state[s] == rdbank_pkg::SLOT_FREE) begin
        return s;
      end
    end
    return -1;
  endfunction

  // Compare every output with the model in the middle of the cycle
  task automatic check_cycle();
    int free_s;
    int t;
    int exp_onehot;
    free_s = lowest_free();
    check_equal("o_res_ready", 32'(o_res_ready), 32'(free_s >= 0));
    if (free_s >= 0) begin
      check_equal("o_res_addr", 32'(o_res_addr), free_s);
    end
    res_hs = i_res_valid && (free_s >= 0);
    exp_res_addr = free_s;
    // Input ready follows the driven identifier
    exp_fill = oldest_slot(int'(i_in_id), 1'b1);
    check_equal("o_in_ready", 32'(o_in_ready), 32'(exp_fill >= 0));
    in_hs = i_in_valid && (exp_fill >= 0);
    exp_valid = locked;
    exp_out_id = lock_id;
    exp_out_slot = lock_slot;
    // Lowest identifier with an enabled, unsent beat in its oldest slot
    for (int i = 0; i < NumIds; i++) begin
      t = oldest_slot(i, 1'b0);
      if (!exp_valid && (t >= 0) && (slot_rcvd[t] > slot_sent[t]) && i_release_en[t]) begin
        exp_valid = 1'b1;
        exp_out_id = i;
        exp_out_slot = t;
      end
    end
    check_equal("o_out_valid", 32'(o_out_valid), 32'(exp_valid));
    out_hs = exp_valid && i_out_ready;
    if (exp_valid) begin
      check_equal("o_out_id", 32'(o_out_id), exp_out_id);
      check_equal("o_out_content", 32'(o_out_content),
                  32'(slot_data[exp_out_slot][slot_sent[exp_out_slot]]));
    end
    exp_onehot = out_hs ? (1 << exp_out_slot) : 0;
    check_equal("o_released_onehot", 32'(o_released_onehot), exp_onehot);
  endtask

  // Apply this cycle's handshakes to the model at the clock edge
  task automatic update_model();
    if (res_hs) begin
      slot_state[exp_res_addr] = rdbank_pkg::SLOT_FILLING;
      slot_id[exp_res_addr] = int'(i_res_id);
      slot_seq[exp_res_addr] = next_seq;
      slot_len[exp_res_addr] = int'(i_res_burst_len);
      slot_rcvd[exp_res_addr] = 0;
      slot_sent[exp_res_addr] = 0;
      next_seq++;
    end
    if (in_hs) begin
      slot_data[exp_fill][slot_rcvd[exp_fill]] = i_in_content;
      slot_rcvd[exp_fill]++;
      if (slot_rcvd[exp_fill] == slot_len[exp_fill]) begin
        slot_state[exp_fill] = rdbank_pkg::SLOT_FULL;
      end
    end
    if (out_hs) begin
      slot_sent[exp_out_slot]++;
      // Last beat out frees the slot
      if (slot_sent[exp_out_slot] == slot_len[exp_out_slot]) begin
        slot_state[exp_out_slot] = rdbank_pkg::SLOT_FREE;
      end
    end
    locked = exp_valid && !i_out_ready;
    lock_id = exp_out_id;
    lock_slot = exp_out_slot;
  endtask

  // Check at the falling edge and update the model at the rising one
  task automatic run_cycle();
    @(negedge clk_i);
    check_cycle();
    @(posedge clk_i);
    update_model();
    #2;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row actions
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(row_kind_e kind, int a, int b);
    row_kind.push_back(kind);
    row_a.push_back(a);
    row_b.push_back(b);
  endtask

  task automatic reserve_slot(int id, int len);
    int waited;
    waited = 0;
    i_res_valid = 1'b1;
    i_res_id = IdWidth'(id);
    i_res_burst_len = BurstLenWidth'(len);
    res_hs = 1'b0;
    while (!res_hs) begin
      if (waited >= WaitLimit) begin
        report_timeout("a free slot");
      end else begin
        run_cycle();
        waited++;
      end
    end
    i_res_valid = 1'b0;
  endtask

  task automatic write_beat(int id);
    int          waited;
    logic [31:0] rnd;
    waited = 0;
    rnd = $random(seed);
    i_in_valid = 1'b1;
    i_in_id = IdWidth'(id);
    i_in_content = rnd[DataWidth-1:0];
    in_hs = 1'b0;
    while (!in_hs) begin
      if (waited >= WaitLimit) begin
        report_timeout("input ready");
      end else begin
        run_cycle();
        waited++;
      end
    end
    i_in_valid = 1'b0;
  endtask

  // Ready follows the 8-bit pattern and enables drop while a choice is held
  task automatic drain_beats(int count, int pattern);
    int done_cnt;
    int cyc;
    done_cnt = 0;
    cyc = 0;
    while (done_cnt < count) begin
      if (cyc >= WaitLimit) begin
        report_timeout("released beats");
      end else begin
        i_out_ready = pattern[cyc % 8];
        i_release_en = locked ? '0 : release_mask;
        run_cycle();
        if (out_hs) begin
          done_cnt++;
        end
        cyc++;
      end
    end
    i_out_ready = 1'b0;
    i_release_en = release_mask;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni = 1'b0;
    i_res_valid = 1'b0;
    i_res_id = '0;
    i_res_burst_len = '0;
    i_in_valid = 1'b0;
    i_in_id = '0;
    i_in_content = '0;
    i_release_en = '0;
    i_out_ready = 1'b0;
    release_mask = '0;
    next_seq = 0;
    locked = 1'b0;
    lock_id = 0;
    lock_slot = 0;
    for (int s = 0; s < TotalCapacity; s++) begin
      slot_state[s] = rdbank_pkg::SLOT_FREE;
    end

    // Mixed identifiers with every slot free to release
    add_row(ROW_MASK, 'hFF, 0);
    add_row(ROW_RESERVE, 0, 2);
    add_row(ROW_RESERVE, 1, 1);
    add_row(ROW_RESERVE, 0, 3);
    add_row(ROW_RESERVE, 2, 4);
    add_row(ROW_WRITE, 0, 2);
    add_row(ROW_WRITE, 1, 1);
    add_row(ROW_WRITE, 0, 3);
    add_row(ROW_WRITE, 2, 4);
    add_row(ROW_DRAIN, 10, 'hFF);
    // Bank filled to capacity so that ready drops after the last reservation
    add_row(ROW_RESERVE, 3, 1);
    add_row(ROW_RESERVE, 1, 2);
    add_row(ROW_RESERVE, 0, 4);
    add_row(ROW_RESERVE, 2, 1);
    add_row(ROW_RESERVE, 3, 2);
    add_row(ROW_RESERVE, 1, 1);
    add_row(ROW_RESERVE, 0, 1);
    add_row(ROW_RESERVE, 2, 3);
    // Slot 2 holds the oldest burst of identifier 0 and is blocked
    add_row(ROW_MASK, 'hFB, 0);
    add_row(ROW_WRITE, 3, 3);
    add_row(ROW_WRITE, 1, 3);
    add_row(ROW_WRITE, 0, 5);
    add_row(ROW_WRITE, 2, 4);
    add_row(ROW_DRAIN, 10, 'h8B);
    add_row(ROW_MASK, 'hFF, 0);
    add_row(ROW_DRAIN, 5, 'h8B);

    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // Idle outputs straight out of reset
    run_cycle();

    for (int r = 0; r < row_kind.size(); r++) begin
      case (row_kind[r])
        ROW_RESERVE: reserve_slot(row_a[r], row_b[r]);
        ROW_WRITE: begin
          for (int b = 0; b < row_b[r]; b++) begin
            write_beat(row_a[r]);
          end
        end
        ROW_MASK: begin
          release_mask = TotalCapacity'(row_a[r]);
          i_release_en = release_mask;
          run_cycle();
        end
        default: drain_beats(row_a[r], row_b[r]);
      endcase
    end

    // All slots are free again and nothing is left to release
    repeat (3) run_cycle();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== rtl/read_data_bank.sv ====
// Read data bank top level: slot table, identifier lists, release arbiter and beat store

`timescale 1ns/1ps

module read_data_bank #(
  parameter int NumIds = rdbank_pkg::NumIds,
  parameter int TotalCapacity = rdbank_pkg::TotalCapacity,
  parameter int MaxBurstLen = rdbank_pkg::MaxBurstLen,
  parameter int DataWidth = rdbank_pkg::DataWidth,
  localparam int IdWidth = (NumIds > 1) ? $clog2(NumIds) : 1,
  localparam int BankAddrWidth = (TotalCapacity > 1) ? $clog2(TotalCapacity) : 1,
  localparam int BurstLenWidth = $clog2(MaxBurstLen + 1),
  localparam int BeatIdxWidth = (MaxBurstLen > 1) ? $clog2(MaxBurstLen) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Reservation
  input  logic                     i_res_valid,
  input  logic [IdWidth-1:0]       i_res_id,
  input  logic [BurstLenWidth-1:0] i_res_burst_len,
  output logic                     o_res_ready,
  output logic [BankAddrWidth-1:0] o_res_addr,

  // Data input from the memory side
  input  logic                     i_in_valid,
  input  logic [IdWidth-1:0]       i_in_id,
  input  logic [DataWidth-1:0]     i_in_content,
  output logic                     o_in_ready,

  // Release enables, one level per slot
  input  logic [TotalCapacity-1:0] i_release_en,

  // Data output to the requester
  output logic                     o_out_valid,
  output logic [IdWidth-1:0]       o_out_id,
  output logic [DataWidth-1:0]     o_out_content,
  input  logic                     i_out_ready,
  output logic [TotalCapacity-1:0] o_released_onehot
);

  logic                              res_en;
  logic                              in_en;
  logic                              out_en;
  logic [BankAddrWidth-1:0]          fill_slot;
  logic [BankAddrWidth-1:0]          out_slot;
  logic [BeatIdxWidth-1:0]           wr_beat;
  logic [BeatIdxWidth-1:0]           rd_beat;
  logic                              fill_last;
  logic                              drain_last;
  logic [TotalCapacity-1:0]          beat_avail;
  logic [NumIds-1:0][BankAddrWidth-1:0] tail_slot;
  logic [NumIds-1:0]                 tail_avail;

  // Handshakes
  assign res_en = i_res_valid && o_res_ready;
  assign in_en  = i_in_valid && o_in_ready;
  assign out_en = o_out_valid && i_out_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Slot bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  rdbank_slot_table #(
    .TotalCapacity (TotalCapacity),
    .MaxBurstLen   (MaxBurstLen)
  ) slot_table_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .i_res_en        (res_en),
    .i_res_burst_len (i_res_burst_len),
    .i_in_en         (in_en),
    .i_in_slot       (fill_slot),
    .i_out_en        (out_en),
    .i_out_slot      (out_slot),
    .o_free_slot     (o_res_addr),
    .o_any_free      (o_res_ready),
    .o_wr_beat       (wr_beat),
    .o_fill_last     (fill_last),
    .o_rd_beat       (rd_beat),
    .o_drain_last    (drain_last),
    .o_beat_avail    (beat_avail)
  );

  rdbank_id_lists #(
    .NumIds        (NumIds),
    .TotalCapacity (TotalCapacity)
  ) id_lists_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_res_en     (res_en),
    .i_res_id     (i_res_id),
    .i_res_slot   (o_res_addr),
    .i_in_id      (i_in_id),
    .i_in_en      (in_en),
    .i_fill_last  (fill_last),
    .i_out_en     (out_en),
    .i_out_id     (o_out_id),
    .i_drain_last (drain_last),
    .o_fill_slot  (fill_slot),
    .o_fill_avail (o_in_ready),
    .o_tail_slot  (tail_slot),
    .o_tail_avail (tail_avail)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Release and storage
  ////////////////////////////////////////////////////////////////////////////

  rdbank_release_arbiter #(
    .NumIds        (NumIds),
    .TotalCapacity (TotalCapacity)
  ) release_arbiter_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_tail_slot       (tail_slot),
    .i_tail_avail      (tail_avail),
    .i_beat_avail      (beat_avail),
    .i_release_en      (i_release_en),
    .i_out_ready       (i_out_ready),
    .o_out_valid       (o_out_valid),
    .o_out_id          (o_out_id),
    .o_out_slot        (out_slot),
    .o_released_onehot (o_released_onehot)
  );

  rdbank_beat_store #(
    .TotalCapacity (TotalCapacity),
    .MaxBurstLen   (MaxBurstLen),
    .DataWidth     (DataWidth)
  ) beat_store_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_wr_en      (in_en),
    .i_wr_slot    (fill_slot),
    .i_wr_beat    (wr_beat),
    .i_wr_content (i_in_content),
    .i_rd_slot    (out_slot),
    .i_rd_beat    (rd_beat),
    .o_rd_content (o_out_content)
  );

endmodule

// ==== rtl/rdbank_release_arbiter.sv ====
// Release arbiter: picks the next identifier and slot to release, holds it under back-pressure

`timescale 1ns/1ps

module rdbank_release_arbiter #(
  parameter int NumIds = rdbank_pkg::NumIds,
  parameter int TotalCapacity = rdbank_pkg::TotalCapacity,
  localparam int IdWidth = (NumIds > 1) ? $clog2(NumIds) : 1,
  localparam int BankAddrWidth = (TotalCapacity > 1) ? $clog2(TotalCapacity) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  input  logic [NumIds-1:0][BankAddrWidth-1:0]  i_tail_slot,
  input  logic [NumIds-1:0]                     i_tail_avail,
  input  logic [TotalCapacity-1:0]              i_beat_avail,
  input  logic [TotalCapacity-1:0]              i_release_en,

  input  logic                                  i_out_ready,
  output logic                                  o_out_valid,
  output logic [IdWidth-1:0]                    o_out_id,
  output logic [BankAddrWidth-1:0]              o_out_slot,
  output logic [TotalCapacity-1:0]              o_released_onehot
);

  logic [NumIds-1:0]        eligible;
  logic                     sel_valid;
  logic [IdWidth-1:0]       sel_id;
  logic [BankAddrWidth-1:0] sel_slot;

  // Choice frozen while the requester stalls
  logic                     lock_q;
  logic [IdWidth-1:0]       lock_id_q;
  logic [BankAddrWidth-1:0] lock_slot_q;

  // Tail slot must hold an unsent beat and be enabled for release
  for (genvar i = 0; i < NumIds; i++) begin : g_elig
    assign eligible[i] = i_tail_avail[i] && i_beat_avail[i_tail_slot[i]] &&
                         i_release_en[i_tail_slot[i]];
  end

  // Lowest eligible identifier wins
  always_comb begin
    sel_valid = 1'b0;
    sel_id    = '0;
    sel_slot  = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel_valid = 1'b1;
        sel_id    = IdWidth'(i);
        sel_slot  = i_tail_slot[i];
      end
    end
  end

  assign o_out_valid = lock_q || sel_valid;
  assign o_out_id    = lock_q ? lock_id_q : sel_id;
  assign o_out_slot  = lock_q ? lock_slot_q : sel_slot;

  // One-hot pulse of the released slot on each handshake
  assign o_released_onehot = (o_out_valid && i_out_ready) ?
                             (TotalCapacity'(1) << o_out_slot) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= o_out_valid && !i_out_ready;
    end
  end

  // Track the presented choice until the lock takes over
  always_ff @(posedge clk_i) begin
    if (!lock_q) begin
      lock_id_q   <= sel_id;
      lock_slot_q <= sel_slot;
    end
  end

endmodule

// ==== rtl/rdbank_id_lists.sv ====
// Identifier lists: per-identifier head, fill and tail pointers, counts, next-pointer array

`timescale 1ns/1ps

module rdbank_id_lists #(
  parameter int NumIds = rdbank_pkg::NumIds,
  parameter int TotalCapacity = rdbank_pkg::TotalCapacity,
  localparam int IdWidth = (NumIds > 1) ? $clog2(NumIds) : 1,
  localparam int BankAddrWidth = (TotalCapacity > 1) ? $clog2(TotalCapacity) : 1,
  localparam int CntWidth = $clog2(TotalCapacity + 1)
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // New slot appended to a list
  input  logic                                  i_res_en,
  input  logic [IdWidth-1:0]                    i_res_id,
  input  logic [BankAddrWidth-1:0]              i_res_slot,

  // Input beat, fill pointer moves on the last one
  input  logic [IdWidth-1:0]                    i_in_id,
  input  logic                                  i_in_en,
  input  logic                                  i_fill_last,

  // Output beat, tail pointer moves on the last one
  input  logic                                  i_out_en,
  input  logic [IdWidth-1:0]                    i_out_id,
  input  logic                                  i_drain_last,

  output logic [BankAddrWidth-1:0]              o_fill_slot,
  output logic                                  o_fill_avail,
  output logic [NumIds-1:0][BankAddrWidth-1:0]  o_tail_slot,
  output logic [NumIds-1:0]                     o_tail_avail
);

  // Link from each slot to the one reserved after it, same identifier
  logic [BankAddrWidth-1:0] next_q [TotalCapacity];

  // Head is the last reserved slot, fill the oldest unfilled, tail the oldest
  logic [BankAddrWidth-1:0] head_q [NumIds];
  logic [BankAddrWidth-1:0] fill_q [NumIds];
  logic [BankAddrWidth-1:0] tail_q [NumIds];

  // Unfilled slots sit between fill and head, all slots between tail and head
  logic [CntWidth-1:0] unfilled_q [NumIds];
  logic [CntWidth-1:0] total_q    [NumIds];

  ////////////////////////////////////////////////////////////////////////////
  // Next-pointer array
  ////////////////////////////////////////////////////////////////////////////

  // Link the old head to the new slot, unless the list was empty
  always_ff @(posedge clk_i) begin
    if (i_res_en && (total_q[i_res_id] != '0)) begin
      next_q[head_q[i_res_id]] <= i_res_slot;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-identifier pointers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumIds; i++) begin : g_id
    logic                res_hit;
    logic                fill_adv;
    logic                drain_adv;
    logic [CntWidth-1:0] unfilled_left;
    logic [CntWidth-1:0] total_left;

    assign res_hit   = i_res_en && (i_res_id == IdWidth'(i));
    assign fill_adv  = i_in_en && i_fill_last && (i_in_id == IdWidth'(i));
    assign drain_adv = i_out_en && i_drain_last && (i_out_id == IdWidth'(i));

    // Counts after this cycle's fill and drain, before the reservation
    assign unfilled_left = unfilled_q[i] - CntWidth'(fill_adv);
    assign total_left    = total_q[i] - CntWidth'(drain_adv);

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        head_q[i]     <= '0;
        fill_q[i]     <= '0;
        tail_q[i]     <= '0;
        unfilled_q[i] <= '0;
        total_q[i]    <= '0;
      end else begin
        unfilled_q[i] <= unfilled_left + CntWidth'(res_hit);
        total_q[i]    <= total_left + CntWidth'(res_hit);

        if (res_hit) begin
          head_q[i] <= i_res_slot;
        end

        // Fill piggybacks on the reservation when nothing unfilled is left
        if (res_hit && (unfilled_left == '0)) begin
          fill_q[i] <= i_res_slot;
        end else if (fill_adv) begin
          fill_q[i] <= next_q[fill_q[i]];
        end

        // Same for the tail once the list drains empty
        if (res_hit && (total_left == '0)) begin
          tail_q[i] <= i_res_slot;
        end else if (drain_adv) begin
          tail_q[i] <= next_q[tail_q[i]];
        end
      end
    end

    assign o_tail_slot[i]  = tail_q[i];
    assign o_tail_avail[i] = (total_q[i] != '0);
  end

  // Input side looks up the identifier of the incoming beat
  assign o_fill_slot  = fill_q[i_in_id];
  assign o_fill_avail = (unfilled_q[i_in_id] != '0);

endmodule

// ==== rtl/rdbank_slot_table.sv ====
// Slot table: per-slot state, burst length, received and sent counters, free-slot search

`timescale 1ns/1ps

module rdbank_slot_table #(
  parameter int TotalCapacity = rdbank_pkg::TotalCapacity,
  parameter int MaxBurstLen = rdbank_pkg::MaxBurstLen,
  localparam int BankAddrWidth = (TotalCapacity > 1) ? $clog2(TotalCapacity) : 1,
  localparam int BurstLenWidth = $clog2(MaxBurstLen + 1),
  localparam int BeatIdxWidth = (MaxBurstLen > 1) ? $clog2(MaxBurstLen) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Reservation of the lowest free slot
  input  logic                     i_res_en,
  input  logic [BurstLenWidth-1:0] i_res_burst_len,

  // Input beat written into this slot
  input  logic                     i_in_en,
  input  logic [BankAddrWidth-1:0] i_in_slot,

  // Output beat released from this slot
  input  logic                     i_out_en,
  input  logic [BankAddrWidth-1:0] i_out_slot,

  output logic [BankAddrWidth-1:0] o_free_slot,
  output logic                     o_any_free,
  output logic [BeatIdxWidth-1:0]  o_wr_beat,
  output logic                     o_fill_last,
  output logic [BeatIdxWidth-1:0]  o_rd_beat,
  output logic                     o_drain_last,
  output logic [TotalCapacity-1:0] o_beat_avail
);

  rdbank_pkg::slot_state_e  state_q [TotalCapacity];
  logic [BurstLenWidth-1:0] len_q   [TotalCapacity];
  logic [BurstLenWidth-1:0] rcvd_q  [TotalCapacity];
  logic [BurstLenWidth-1:0] sent_q  [TotalCapacity];

  logic [BurstLenWidth-1:0] rcvd_next;
  logic [BurstLenWidth-1:0] sent_next;

  ////////////////////////////////////////////////////////////////////////////
  // Free-slot search
  ////////////////////////////////////////////////////////////////////////////

  // Walk downwards so the lowest free slot is the last one kept
  always_comb begin
    o_free_slot = '0;
    o_any_free  = 1'b0;
    for (int s = TotalCapacity - 1; s >= 0; s--) begin
      if (state_q[s] == rdbank_pkg::SLOT_FREE) begin
        o_free_slot = BankAddrWidth'(s);
        o_any_free  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat indices
  ////////////////////////////////////////////////////////////////////////////

  // Write index is the received count, last when it reaches the length
  assign rcvd_next   = rcvd_q[i_in_slot] + 1'b1;
  assign o_wr_beat   = rcvd_q[i_in_slot][BeatIdxWidth-1:0];
  assign o_fill_last = (rcvd_next == len_q[i_in_slot]);

  // Read index is the sent count
  assign sent_next    = sent_q[i_out_slot] + 1'b1;
  assign o_rd_beat    = sent_q[i_out_slot][BeatIdxWidth-1:0];
  assign o_drain_last = (sent_next == len_q[i_out_slot]);

  // A beat waits in the slot while received runs ahead of sent
  for (genvar s = 0; s < TotalCapacity; s++) begin : g_avail
    assign o_beat_avail[s] = (rcvd_q[s] > sent_q[s]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slot registers
  ////////////////////////////////////////////////////////////////////////////

  // Reservation hits a free slot, input and output only occupied ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '{default: rdbank_pkg::SLOT_FREE};
      len_q   <= '{default: '0};
      rcvd_q  <= '{default: '0};
      sent_q  <= '{default: '0};
    end else begin
      if (i_res_en) begin
        state_q[o_free_slot] <= rdbank_pkg::SLOT_FILLING;
        len_q[o_free_slot]   <= i_res_burst_len;
        rcvd_q[o_free_slot]  <= '0;
        sent_q[o_free_slot]  <= '0;
      end
      if (i_in_en) begin
        rcvd_q[i_in_slot] <= rcvd_next;
        if (o_fill_last) begin
          state_q[i_in_slot] <= rdbank_pkg::SLOT_FULL;
        end
      end
      // Last beat out hands the slot back to the free pool
      if (i_out_en) begin
        sent_q[i_out_slot] <= sent_next;
        if (o_drain_last) begin
          state_q[i_out_slot] <= rdbank_pkg::SLOT_FREE;
        end
      end
    end
  end

endmodule

// ==== rtl/rdbank_beat_store.sv ====
// Beat storage: register array of beat contents per slot, one write port, one read port

`timescale 1ns/1ps

module rdbank_beat_store #(
  parameter int TotalCapacity = rdbank_pkg::TotalCapacity,
  parameter int MaxBurstLen = rdbank_pkg::MaxBurstLen,
  parameter int DataWidth = rdbank_pkg::DataWidth,
  localparam int BankAddrWidth = (TotalCapacity > 1) ? $clog2(TotalCapacity) : 1,
  localparam int BeatIdxWidth = (MaxBurstLen > 1) ? $clog2(MaxBurstLen) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Write side, driven by the input handshake
  input  logic                     i_wr_en,
  input  logic [BankAddrWidth-1:0] i_wr_slot,
  input  logic [BeatIdxWidth-1:0]  i_wr_beat,
  input  logic [DataWidth-1:0]     i_wr_content,

  // Read side, follows the release selection
  input  logic [BankAddrWidth-1:0] i_rd_slot,
  input  logic [BeatIdxWidth-1:0]  i_rd_beat,
  output logic [DataWidth-1:0]     o_rd_content
);

  // One row per slot, one column per beat of the burst
  logic [DataWidth-1:0] beats_q [TotalCapacity][MaxBurstLen];

  // No writes land while reset is held
  always_ff @(posedge clk_i) begin
    if (rst_ni && i_wr_en) begin
      beats_q[i_wr_slot][i_wr_beat] <= i_wr_content;
    end
  end

  // Asynchronous read for zero-latency output
  assign o_rd_content = beats_q[i_rd_slot][i_rd_beat];

endmodule

// ==== rtl/rdbank_pkg.sv ====
// Read data bank package: default sizes, derived widths and slot state enum

package rdbank_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////////////////////////////////////////

  // Number of AXI identifiers
  parameter int NumIds = 4;

  // Number of slots in the bank
  parameter int TotalCapacity = 8;

  // Most beats held by one slot
  parameter int MaxBurstLen = 4;

  // Beat content, identifier excluded
  parameter int DataWidth = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Derived widths
  ////////////////////////////////////////////////////////////////////////////

  parameter int IdWidth = (NumIds > 1) ? $clog2(NumIds) : 1;
  parameter int BankAddrWidth = (TotalCapacity > 1) ? $clog2(TotalCapacity) : 1;
  // Counts 0 to MaxBurstLen inclusive
  parameter int BurstLenWidth = $clog2(MaxBurstLen + 1);

  // Life cycle of one slot
  typedef enum logic [1:0] {
    SLOT_FREE    = 2'd0,
    SLOT_FILLING = 2'd1,
    SLOT_FULL    = 2'd2
  } slot_state_e;

endpackage
